// ==== verilog/cps_mmr_pkg.sv ====
`default_nettype none

package cps_mmr_pkg;

    // CPS-B configuration byte chain, byte 0 holds the last byte shifted in
    localparam int CFG_BYTES         = 23;
    localparam int CFG_IDX_ID        = 0;
    localparam int CFG_IDX_ID_VAL    = 1;
    localparam int CFG_IDX_MULT1     = 2;
    localparam int CFG_IDX_MULT2     = 3;
    localparam int CFG_IDX_RSLT0     = 4;
    localparam int CFG_IDX_RSLT1     = 5;
    localparam int CFG_IDX_LAYER     = 6;
    localparam int CFG_IDX_PRIO0     = 7;
    localparam int CFG_IDX_PRIO1     = 8;
    localparam int CFG_IDX_PRIO2     = 9;
    localparam int CFG_IDX_PRIO3     = 10;
    localparam int CFG_IDX_IN2       = 11;
    localparam int CFG_IDX_IN3       = 12;
    localparam int CFG_IDX_PAL_PAGE  = 13;
    localparam int CFG_IDX_MASK0     = 14;
    localparam int CFG_IDX_MASK1     = 15;
    localparam int CFG_IDX_MASK2     = 16;
    localparam int CFG_IDX_MASK3     = 17;
    localparam int CFG_IDX_GAME      = 18;
    // two bytes each, low byte first
    localparam int CFG_IDX_BANK_OFS  = 19;
    localparam int CFG_IDX_BANK_MASK = 21;

    // CPS-A fixed word addresses
    localparam logic [4:0] A_OBJ_BASE   = 5'h00;
    localparam logic [4:0] A_VRAM1_BASE = 5'h01;
    localparam logic [4:0] A_VRAM2_BASE = 5'h02;
    localparam logic [4:0] A_VRAM3_BASE = 5'h03;
    localparam logic [4:0] A_ROW_BASE   = 5'h04;
    localparam logic [4:0] A_PAL_BASE   = 5'h05;
    localparam logic [4:0] A_HPOS1      = 5'h06;
    localparam logic [4:0] A_VPOS1      = 5'h07;
    localparam logic [4:0] A_HPOS2      = 5'h08;
    localparam logic [4:0] A_VPOS2      = 5'h09;
    localparam logic [4:0] A_HPOS3      = 5'h0a;
    localparam logic [4:0] A_VPOS3      = 5'h0b;
    localparam logic [4:0] A_HSTAR1     = 5'h0c;
    localparam logic [4:0] A_VSTAR1     = 5'h0d;
    localparam logic [4:0] A_HSTAR2     = 5'h0e;
    localparam logic [4:0] A_VSTAR2     = 5'h0f;
    localparam logic [4:0] A_ROW_OFFSET = 5'h10;
    localparam logic [4:0] A_PPU_CTRL   = 5'h11;

    // CPS-B reset values, default layer order 3,2,1,0
    localparam logic [15:0] LAYER_CTRL_RST  = {3'd0, 2'd3, 2'd2, 2'd1, 2'd0, 5'd0};
    localparam logic [15:0] PRIO_RST        = 16'hffff;
    localparam logic [5:0]  PAL_PAGE_EN_RST = 6'h3f;
    localparam logic [15:0] OPEN_BUS        = 16'hffff;

    // palette geometry
    localparam int PAL_PAGES      = 6;
    localparam int PAL_PAGE_WORDS = 512;
    localparam int PAL_WORD_W     = 9;
    localparam int PAL_SRC_W      = 23;
    localparam int PAL_BASE_SHIFT = 7;

    // copy sequencer states
    localparam logic [1:0] SEQ_IDLE = 2'd0;
    localparam logic [1:0] SEQ_FIND = 2'd1;
    localparam logic [1:0] SEQ_COPY = 2'd2;

endpackage

`default_nettype wire

// ==== verilog/cpsb_cfg_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpsb_cfg_chain
    import cps_mmr_pkg::*;
(
    input  wire         clk,
    input  wire         cfg_we,
    input  wire  [7:0]  cfg_data,
    output logic [4:0]  addr_id,
    output logic [4:0]  addr_mult1,
    output logic [4:0]  addr_mult2,
    output logic [4:0]  addr_rslt0,
    output logic [4:0]  addr_rslt1,
    output logic [4:0]  addr_layer,
    output logic [4:0]  addr_prio0,
    output logic [4:0]  addr_prio1,
    output logic [4:0]  addr_prio2,
    output logic [4:0]  addr_prio3,
    output logic [4:0]  addr_pal_page,
    output logic [4:0]  addr_in2,
    output logic [4:0]  addr_in3,
    output logic [7:0]  cpsb_id,
    output logic [7:0]  layer_mask0,
    output logic [7:0]  layer_mask1,
    output logic [7:0]  layer_mask2,
    output logic [7:0]  layer_mask3,
    output logic [7:0]  layer_mask4,
    output logic [5:0]  game,
    output logic [15:0] bank_offset,
    output logic [15:0] bank_mask
);

    logic [7:0] cfg_q [0:CFG_BYTES-1];

    // loaded once by the system after power up
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            cfg_q[0] <= cfg_data;
            for (int i = 1; i < CFG_BYTES; i++) begin
                cfg_q[i] <= cfg_q[i-1];
            end
        end
    end

    // byte addresses in the chain, the bus uses word addresses
    assign addr_id       = cfg_q[CFG_IDX_ID][5:1];
    assign addr_mult1    = cfg_q[CFG_IDX_MULT1][5:1];
    assign addr_mult2    = cfg_q[CFG_IDX_MULT2][5:1];
    assign addr_rslt0    = cfg_q[CFG_IDX_RSLT0][5:1];
    assign addr_rslt1    = cfg_q[CFG_IDX_RSLT1][5:1];
    assign addr_layer    = cfg_q[CFG_IDX_LAYER][5:1];
    assign addr_prio0    = cfg_q[CFG_IDX_PRIO0][5:1];
    assign addr_prio1    = cfg_q[CFG_IDX_PRIO1][5:1];
    assign addr_prio2    = cfg_q[CFG_IDX_PRIO2][5:1];
    assign addr_prio3    = cfg_q[CFG_IDX_PRIO3][5:1];
    assign addr_in2      = cfg_q[CFG_IDX_IN2][5:1];
    assign addr_in3      = cfg_q[CFG_IDX_IN3][5:1];
    assign addr_pal_page = cfg_q[CFG_IDX_PAL_PAGE][5:1];

    assign cpsb_id     = cfg_q[CFG_IDX_ID_VAL];
    assign layer_mask0 = cfg_q[CFG_IDX_MASK0];
    assign layer_mask1 = cfg_q[CFG_IDX_MASK1];
    assign layer_mask2 = cfg_q[CFG_IDX_MASK2];
    assign layer_mask3 = cfg_q[CFG_IDX_MASK3];
    // layer 4 shares the mask of layer 3
    assign layer_mask4 = cfg_q[CFG_IDX_MASK3];

    // ROM mapper fields
    assign game        = cfg_q[CFG_IDX_GAME][5:0];
    assign bank_offset = {cfg_q[CFG_IDX_BANK_OFS+1], cfg_q[CFG_IDX_BANK_OFS]};
    assign bank_mask   = {cfg_q[CFG_IDX_BANK_MASK+1], cfg_q[CFG_IDX_BANK_MASK]};

endmodule

`default_nettype wire

// ==== verilog/cpsa_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpsa_regs
    import cps_mmr_pkg::*;
(
    input  wire         clk,
    input  wire         reg_rst,
    input  wire         ppu1_cs,
    input  wire  [4:0]  addr,
    input  wire  [1:0]  dsn,
    input  wire  [15:0] cpu_dout,
    input  wire         obj_dma_clr,
    output logic [15:0] vram_obj_base,
    output logic [15:0] vram1_base,
    output logic [15:0] vram2_base,
    output logic [15:0] vram3_base,
    output logic [15:0] vram_row_base,
    output logic [15:0] pal_base,
    output logic [15:0] hpos1,
    output logic [15:0] hpos2,
    output logic [15:0] hpos3,
    output logic [15:0] vpos1,
    output logic [15:0] vpos2,
    output logic [15:0] vpos3,
    output logic [15:0] hstar1,
    output logic [15:0] hstar2,
    output logic [15:0] vstar1,
    output logic [15:0] vstar2,
    output logic [15:0] row_offset,
    output logic [15:0] ppu_ctrl,
    output logic        obj_dma_ok,
    output logic        pal_copy
);

    logic [15:0] regs_q [0:A_PPU_CTRL];
    logic        wr_hit;
    logic        armed_q;

    // dsn is active low, a high bit keeps the old byte
    function automatic logic [15:0] lane_merge(input logic [15:0] old_val,
                                               input logic [15:0] new_val,
                                               input logic [1:0]  lane_n);
        return {lane_n[1] ? old_val[15:8] : new_val[15:8],
                lane_n[0] ? old_val[7:0]  : new_val[7:0]};
    endfunction

    assign wr_hit = ppu1_cs && (addr <= A_PPU_CTRL);

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            for (int i = 0; i <= int'(A_PPU_CTRL); i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_hit) begin
            regs_q[addr] <= lane_merge(regs_q[addr], cpu_dout, dsn);
        end
    end

    // object DMA request, a new base write beats the clear
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            obj_dma_ok <= 1'b0;
        end else if (ppu1_cs && addr == A_OBJ_BASE) begin
            obj_dma_ok <= 1'b1;
        end else if (obj_dma_clr) begin
            obj_dma_ok <= 1'b0;
        end
    end

    // hold the copy request until the CPU releases the chip select
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            armed_q <= 1'b0;
        end else if (ppu1_cs && addr == A_PAL_BASE) begin
            armed_q <= 1'b1;
        end else if (pal_copy) begin
            armed_q <= 1'b0;
        end
    end

    assign pal_copy = armed_q && !ppu1_cs;

    assign vram_obj_base = regs_q[A_OBJ_BASE];
    assign vram1_base    = regs_q[A_VRAM1_BASE];
    assign vram2_base    = regs_q[A_VRAM2_BASE];
    assign vram3_base    = regs_q[A_VRAM3_BASE];
    assign vram_row_base = regs_q[A_ROW_BASE];
    assign pal_base      = regs_q[A_PAL_BASE];
    assign hpos1         = regs_q[A_HPOS1];
    assign vpos1         = regs_q[A_VPOS1];
    assign hpos2         = regs_q[A_HPOS2];
    assign vpos2         = regs_q[A_VPOS2];
    assign hpos3         = regs_q[A_HPOS3];
    assign vpos3         = regs_q[A_VPOS3];
    assign hstar1        = regs_q[A_HSTAR1];
    assign vstar1        = regs_q[A_VSTAR1];
    assign hstar2        = regs_q[A_HSTAR2];
    assign vstar2        = regs_q[A_VSTAR2];
    assign row_offset    = regs_q[A_ROW_OFFSET];
    assign ppu_ctrl      = regs_q[A_PPU_CTRL];

endmodule

`default_nettype wire

// ==== verilog/cpsb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpsb_regs
    import cps_mmr_pkg::*;
(
    input  wire         clk,
    input  wire         reg_rst,
    input  wire         ppu2_cs,
    input  wire  [4:0]  addr,
    input  wire  [1:0]  dsn,
    input  wire  [15:0] cpu_dout,
    input  wire  [4:0]  addr_id,
    input  wire  [4:0]  addr_mult1,
    input  wire  [4:0]  addr_mult2,
    input  wire  [4:0]  addr_rslt0,
    input  wire  [4:0]  addr_rslt1,
    input  wire  [4:0]  addr_layer,
    input  wire  [4:0]  addr_prio0,
    input  wire  [4:0]  addr_prio1,
    input  wire  [4:0]  addr_prio2,
    input  wire  [4:0]  addr_prio3,
    input  wire  [4:0]  addr_pal_page,
    input  wire  [4:0]  addr_in2,
    input  wire  [4:0]  addr_in3,
    input  wire  [7:0]  cpsb_id,
    input  wire  [3:0]  start_button,
    input  wire  [3:0]  coin_input,
    input  wire  [7:0]  joystick3,
    input  wire  [7:0]  joystick4,
    output logic [15:0] mmr_dout,
    output logic [15:0] layer_ctrl,
    output logic [15:0] prio0,
    output logic [15:0] prio1,
    output logic [15:0] prio2,
    output logic [15:0] prio3,
    output logic [5:0]  pal_page_en
);

    logic [15:0] mult1;
    logic [15:0] mult2;
    logic [15:0] rslt0;
    logic [15:0] rslt1;
    logic [7:0]  in2;
    logic [7:0]  in3;
    logic [15:0] rd_data;
    logic        wr_en;

    // only full word writes reach the CPS-B registers
    assign wr_en = ppu2_cs && (dsn == 2'b00);

    // players 3 and 4 through the C-board
    assign in2 = {start_button[2], coin_input[2], joystick3[5:0]};
    assign in3 = {start_button[3], coin_input[3], joystick4[5:0]};

    // multiplier, the product trails the operands by one cycle
    always_ff @(posedge clk) begin
        if (wr_en && addr == addr_mult1) begin
            mult1 <= cpu_dout;
        end
        if (wr_en && addr == addr_mult2) begin
            mult2 <= cpu_dout;
        end
        {rslt1, rslt0} <= mult1 * mult2;
    end

    always_comb begin
        rd_data = OPEN_BUS;
        // address 31 never decodes
        if (!(&addr)) begin
            if (addr == addr_id)            rd_data = {4'd0, cpsb_id[7:4], 4'd0, cpsb_id[3:0]};
            else if (addr == addr_mult1)    rd_data = mult1;
            else if (addr == addr_mult2)    rd_data = mult2;
            else if (addr == addr_rslt0)    rd_data = rslt0;
            else if (addr == addr_rslt1)    rd_data = rslt1;
            else if (addr == addr_layer)    rd_data = layer_ctrl;
            else if (addr == addr_prio0)    rd_data = prio0;
            else if (addr == addr_prio1)    rd_data = prio1;
            else if (addr == addr_prio2)    rd_data = prio2;
            else if (addr == addr_prio3)    rd_data = prio3;
            else if (addr == addr_pal_page) rd_data = {10'd0, pal_page_en};
            else if (addr == addr_in2)      rd_data = {in2, in2};
            else if (addr == addr_in3)      rd_data = {in3, in3};
        end
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            layer_ctrl  <= LAYER_CTRL_RST;
            prio0       <= PRIO_RST;
            prio1       <= PRIO_RST;
            prio2       <= PRIO_RST;
            prio3       <= PRIO_RST;
            pal_page_en <= PAL_PAGE_EN_RST;
            mmr_dout    <= OPEN_BUS;
        end else if (ppu2_cs) begin
            mmr_dout <= rd_data;
            if (wr_en && addr == addr_layer)    layer_ctrl  <= cpu_dout;
            if (wr_en && addr == addr_prio0)    prio0       <= cpu_dout;
            if (wr_en && addr == addr_prio1)    prio1       <= cpu_dout;
            if (wr_en && addr == addr_prio2)    prio2       <= cpu_dout;
            if (wr_en && addr == addr_prio3)    prio3       <= cpu_dout;
            if (wr_en && addr == addr_pal_page) pal_page_en <= cpu_dout[5:0];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pal_copy_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module pal_copy_seq
    import cps_mmr_pkg::*;
(
    input  wire                   clk,
    input  wire                   reg_rst,
    input  wire                   pal_copy,
    input  wire  [15:0]           pal_base,
    input  wire  [PAL_PAGES-1:0]  pal_page_en,
    input  wire  [PAL_WORD_W-1:0] word,
    input  wire                   last,
    output logic                  cnt_clr,
    output logic                  cnt_en,
    output logic                  pal_busy,
    output logic                  pal_we,
    output logic [PAL_SRC_W-1:0]  pal_src_addr,
    output logic [11:0]           pal_dst_addr
);

    logic [1:0]                   state_q;
    logic [PAL_PAGES-1:0]         mask_q;
    logic [15:0]                  base_q;
    logic [$clog2(PAL_PAGES)-1:0] page_q;
    logic [$clog2(PAL_PAGES)-1:0] nxt_page;
    logic                         nxt_found;

    // lowest page still waiting in the mask
    always_comb begin
        nxt_found = 1'b0;
        nxt_page  = '0;
        for (int i = PAL_PAGES - 1; i >= 0; i--) begin
            if (mask_q[i]) begin
                nxt_found = 1'b1;
                nxt_page  = i[$clog2(PAL_PAGES)-1:0];
            end
        end
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            state_q <= SEQ_IDLE;
            mask_q  <= '0;
            page_q  <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (pal_copy) begin
                        state_q <= SEQ_FIND;
                        mask_q  <= pal_page_en;
                    end
                end
                SEQ_FIND, SEQ_COPY: begin
                    // next page follows the last word without a gap
                    if (state_q == SEQ_FIND || last) begin
                        if (nxt_found) begin
                            state_q          <= SEQ_COPY;
                            page_q           <= nxt_page;
                            mask_q[nxt_page] <= 1'b0;
                        end else begin
                            state_q <= SEQ_IDLE;
                        end
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == SEQ_IDLE && pal_copy) begin
            base_q <= pal_base;
        end
    end

    assign pal_busy = (state_q != SEQ_IDLE);
    assign pal_we   = (state_q == SEQ_COPY);
    assign cnt_en   = pal_we;
    assign cnt_clr  = (state_q == SEQ_FIND) || (pal_we && last);

    assign pal_dst_addr = 12'(page_q * PAL_PAGE_WORDS) + 12'(word);
    assign pal_src_addr = (PAL_SRC_W'(base_q) << PAL_BASE_SHIFT) + PAL_SRC_W'(pal_dst_addr);

endmodule

`default_nettype wire

// ==== verilog/pal_word_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pal_word_counter
    import cps_mmr_pkg::*;
(
    input  wire                   clk,
    input  wire                   reg_rst,
    input  wire                   cnt_clr,
    input  wire                   cnt_en,
    output logic [PAL_WORD_W-1:0] word,
    output logic                  last
);

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            word <= '0;
        end else if (cnt_clr) begin
            word <= '0;
        end else if (cnt_en) begin
            word <= word + 1'b1;
        end
    end

    // final word of one palette page
    assign last = (word == PAL_WORD_W'(PAL_PAGE_WORDS - 1));

endmodule

`default_nettype wire

// ==== verilog/cps_mmr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cps_mmr_top
    import cps_mmr_pkg::*;
(
    input  wire                  clk,
    input  wire                  reg_rst,
    input  wire                  ppu1_cs,
    input  wire                  ppu2_cs,
    input  wire  [4:0]           addr,
    input  wire  [1:0]           dsn,
    input  wire  [15:0]          cpu_dout,
    output logic [15:0]          mmr_dout,
    input  wire                  obj_dma_clr,
    output logic                 obj_dma_ok,
    input  wire  [3:0]           start_button,
    input  wire  [3:0]           coin_input,
    input  wire  [7:0]           joystick3,
    input  wire  [7:0]           joystick4,
    input  wire                  cfg_we,
    input  wire  [7:0]           cfg_data,
    output logic [15:0]          vram_obj_base,
    output logic [15:0]          vram1_base,
    output logic [15:0]          vram2_base,
    output logic [15:0]          vram3_base,
    output logic [15:0]          vram_row_base,
    output logic [15:0]          pal_base,
    output logic [15:0]          hpos1,
    output logic [15:0]          hpos2,
    output logic [15:0]          hpos3,
    output logic [15:0]          vpos1,
    output logic [15:0]          vpos2,
    output logic [15:0]          vpos3,
    output logic [15:0]          hstar1,
    output logic [15:0]          hstar2,
    output logic [15:0]          vstar1,
    output logic [15:0]          vstar2,
    output logic [15:0]          row_offset,
    output logic [15:0]          ppu_ctrl,
    output logic                 pal_copy,
    output logic [5:0]           game,
    output logic [15:0]          bank_offset,
    output logic [15:0]          bank_mask,
    output logic [15:0]          layer_ctrl,
    output logic [15:0]          prio0,
    output logic [15:0]          prio1,
    output logic [15:0]          prio2,
    output logic [15:0]          prio3,
    output logic [5:0]           pal_page_en,
    output logic [7:0]           layer_mask0,
    output logic [7:0]           layer_mask1,
    output logic [7:0]           layer_mask2,
    output logic [7:0]           layer_mask3,
    output logic [7:0]           layer_mask4,
    output logic                 pal_busy,
    output logic                 pal_we,
    output logic [PAL_SRC_W-1:0] pal_src_addr,
    output logic [11:0]          pal_dst_addr
);

    // CPS-B address map from the configuration chain
    logic [4:0] addr_id;
    logic [4:0] addr_mult1;
    logic [4:0] addr_mult2;
    logic [4:0] addr_rslt0;
    logic [4:0] addr_rslt1;
    logic [4:0] addr_layer;
    logic [4:0] addr_prio0;
    logic [4:0] addr_prio1;
    logic [4:0] addr_prio2;
    logic [4:0] addr_prio3;
    logic [4:0] addr_pal_page;
    logic [4:0] addr_in2;
    logic [4:0] addr_in3;
    logic [7:0] cpsb_id;

    // sequencer to word counter
    logic                  cnt_clr;
    logic                  cnt_en;
    logic [PAL_WORD_W-1:0] word;
    logic                  last;

    cpsb_cfg_chain   u_cfg  (.*);
    cpsa_regs        u_cpsa (.*);
    cpsb_regs        u_cpsb (.*);
    pal_copy_seq     u_seq  (.*);
    pal_word_counter u_cnt  (.*);

endmodule

`default_nettype wire

// ==== tests/tb_cps_mmr.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cps_mmr
    import cps_mmr_pkg::*;
();

    localparam int CYCLE_LIMIT = 12000;

    logic clk, reg_rst, ppu1_cs, ppu2_cs, obj_dma_clr, cfg_we;
    logic [4:0] addr;
    logic [1:0] dsn;
    logic [15:0] cpu_dout, mmr_dout;
    logic [3:0] start_button, coin_input;
    logic [7:0] joystick3, joystick4, cfg_data;
    logic [15:0] vram_obj_base, vram1_base, vram2_base, vram3_base, vram_row_base, pal_base;
    logic [15:0] hpos1, hpos2, hpos3, vpos1, vpos2, vpos3;
    logic [15:0] hstar1, hstar2, vstar1, vstar2, row_offset, ppu_ctrl;
    logic obj_dma_ok, pal_copy, pal_busy, pal_we;
    logic [5:0] game, pal_page_en;
    logic [15:0] bank_offset, bank_mask, layer_ctrl, prio0, prio1, prio2, prio3;
    logic [7:0] layer_mask0, layer_mask1, layer_mask2, layer_mask3, layer_mask4;
    logic [PAL_SRC_W-1:0] pal_src_addr;
    logic [11:0] pal_dst_addr;

    // reference model state
    logic [15:0] cpsa_m [0:17];
    logic [7:0] cfg_m [0:CFG_BYTES-1];
    logic [31:0] used_addr;
    int errors, checks, cycle;
    int copying, exp_page, exp_word, busy_cnt, we_cnt, copies_done, copy_pulses;
    logic [5:0] exp_mask;
    logic [15:0] exp_base;
    logic [PAL_SRC_W-1:0] exp_src;
    logic copy_armed;

    cps_mmr_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, palette copy or bus traffic stalled", cycle);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // an object base write sets the DMA flag on the next cycle
    assert property (@(posedge clk) disable iff (reg_rst)
                     ppu1_cs && addr == A_OBJ_BASE |=> obj_dma_ok)
        else begin
            errors++;
            $display("Fail obj_dma_ok: got %h expected %h", $sampled(obj_dma_ok), 1'b1);
        end

    // a clear without a base write drops the flag
    assert property (@(posedge clk) disable iff (reg_rst)
                     obj_dma_clr && !(ppu1_cs && addr == A_OBJ_BASE) |=> !obj_dma_ok)
        else begin
            errors++;
            $display("Fail obj_dma_ok: got %h expected %h", $sampled(obj_dma_ok), 1'b0);
        end

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic int next_en_page(input logic [5:0] m, input int from);
        for (int i = from; i < PAL_PAGES; i++) begin
            if (m[i]) return i;
        end
        return PAL_PAGES;
    endfunction

    // palette copy reference, sampled before the edge updates
    always @(posedge clk) begin
        if (!reg_rst) begin
            // a pal_base write arms one pulse for the first cycle without chip select
            check_value("pal_copy", 16'(pal_copy), 16'(copy_armed && !ppu1_cs));
            if (pal_copy) begin
                copy_pulses++;
            end
            if (ppu1_cs && addr == A_PAL_BASE) begin
                copy_armed = 1'b1;
            end else if (!ppu1_cs) begin
                copy_armed = 1'b0;
            end
            if (copying == 0 && pal_copy && !pal_busy) begin
                copying  = 1;
                exp_mask = pal_page_en;
                exp_base = pal_base;
                exp_page = next_en_page(pal_page_en, 0);
                exp_word = 0;
                busy_cnt = 0;
                we_cnt   = 0;
            end else if (copying != 0 && pal_busy) begin
                busy_cnt++;
                if (pal_we) begin
                    we_cnt++;
                    exp_src = (PAL_SRC_W'(exp_base) << 7) + PAL_SRC_W'(exp_page * 512 + exp_word);
                    check_value("pal_dst_addr", 16'(pal_dst_addr), 16'(exp_page * 512 + exp_word));
                    check_value("pal_src_addr[22:16]", 16'(pal_src_addr[22:16]), 16'(exp_src[22:16]));
                    check_value("pal_src_addr[15:0]", pal_src_addr[15:0], exp_src[15:0]);
                    exp_word++;
                    if (exp_word == PAL_PAGE_WORDS) begin
                        exp_word = 0;
                        exp_page = next_en_page(exp_mask, exp_page + 1);
                    end
                end
            end else if (copying != 0) begin
                check_value("pal_busy cycles", 16'(busy_cnt), 16'($countones(exp_mask) * 512 + 1));
                check_value("pal_we count", 16'(we_cnt), 16'($countones(exp_mask) * 512));
                copying = 0;
                copies_done++;
            end
        end
    end

    function automatic logic [15:0] cpsa_out(input int idx);
        case (idx)
            0: return vram_obj_base;
            1: return vram1_base;
            2: return vram2_base;
            3: return vram3_base;
            4: return vram_row_base;
            5: return pal_base;
            6: return hpos1;
            7: return vpos1;
            8: return hpos2;
            9: return vpos2;
            10: return hpos3;
            11: return vpos3;
            12: return hstar1;
            13: return vstar1;
            14: return hstar2;
            15: return vstar2;
            16: return row_offset;
            default: return ppu_ctrl;
        endcase
    endfunction

    task automatic cpsa_write(input int a, input logic [15:0] d, input logic [1:0] lanes,
                              input int hold);
        @(negedge clk);
        ppu1_cs  = 1'b1;
        addr     = 5'(a);
        dsn      = lanes;
        cpu_dout = d;
        repeat (hold) @(negedge clk);
        ppu1_cs = 1'b0;
        obj_dma_clr = 1'b0;
        if (!lanes[1]) cpsa_m[a][15:8] = d[15:8];
        if (!lanes[0]) cpsa_m[a][7:0] = d[7:0];
    endtask

    task automatic cpsb_access(input logic [4:0] a, input logic [15:0] d, input logic [1:0] lanes);
        @(negedge clk);
        ppu2_cs  = 1'b1;
        addr     = a;
        dsn      = lanes;
        cpu_dout = d;
        @(negedge clk);
        ppu2_cs = 1'b0;
    endtask

    task automatic cpsb_read_check(input string name, input logic [4:0] a, input logic [15:0] exp);
        cpsb_access(a, 16'h0, 2'b11);
        check_value(name, mmr_dout, exp);
    endtask

    task automatic wait_copies(input int target);
        while (copies_done < target) @(negedge clk);
    endtask

    function automatic logic [4:0] cfg_addr(input int idx);
        return cfg_m[idx][5:1];
    endfunction

    initial begin
        logic [15:0] v;
        logic [15:0] m1;
        logic [15:0] m2;
        logic [7:0] in_b;
        int a;
        void'($urandom(32'hd867_94b2));
        {ppu1_cs, ppu2_cs, obj_dma_clr, cfg_we, addr, dsn, cpu_dout} = '0;
        {start_button, coin_input, joystick3, joystick4, cfg_data} = '0;
        {errors, checks, cycle, copying, copies_done, copy_pulses} = '0;
        copy_armed = 1'b0;
        for (int i = 0; i < 18; i++) cpsa_m[i] = '0;
        reg_rst = 1'b1;
        repeat (8) @(negedge clk);
        reg_rst = 1'b0;
        @(negedge clk);

        check_value("control outputs", 16'({pal_copy, pal_busy, pal_we, obj_dma_ok}), 16'h0);
        check_value("mmr_dout", mmr_dout, 16'hffff);
        for (int i = 0; i < 18; i++) check_value("cpsa register", cpsa_out(i), 16'h0);
        check_value("layer_ctrl", layer_ctrl, 16'h1c80);
        check_value("prio0", prio0, 16'hffff);
        check_value("prio1", prio1, 16'hffff);
        check_value("prio2", prio2, 16'hffff);
        check_value("prio3", prio3, 16'hffff);
        check_value("pal_page_en", 16'(pal_page_en), 16'h003f);

        // distinct even byte addresses below 62 for the CPS-B map
        used_addr = '0;
        for (int i = 0; i < CFG_BYTES; i++) cfg_m[i] = 8'($urandom);
        for (int i = 0; i <= CFG_IDX_PAL_PAGE; i++) begin
            if (i != CFG_IDX_ID_VAL) begin
                do a = $urandom_range(0, 30); while (used_addr[a]);
                used_addr[a] = 1'b1;
                cfg_m[i] = 8'(a << 1);
            end
        end
        for (int i = CFG_BYTES - 1; i >= 0; i--) begin
            @(negedge clk);
            cfg_we   = 1'b1;
            cfg_data = cfg_m[i];
        end
        @(negedge clk);
        cfg_we = 1'b0;
        check_value("game", 16'(game), 16'(cfg_m[CFG_IDX_GAME][5:0]));
        check_value("bank_offset", bank_offset,
                    {cfg_m[CFG_IDX_BANK_OFS+1], cfg_m[CFG_IDX_BANK_OFS]});
        check_value("bank_mask", bank_mask,
                    {cfg_m[CFG_IDX_BANK_MASK+1], cfg_m[CFG_IDX_BANK_MASK]});
        check_value("layer_mask0", 16'(layer_mask0), 16'(cfg_m[CFG_IDX_MASK0]));
        check_value("layer_mask1", 16'(layer_mask1), 16'(cfg_m[CFG_IDX_MASK1]));
        check_value("layer_mask2", 16'(layer_mask2), 16'(cfg_m[CFG_IDX_MASK2]));
        check_value("layer_mask3", 16'(layer_mask3), 16'(cfg_m[CFG_IDX_MASK3]));
        check_value("layer_mask4", 16'(layer_mask4), 16'(cfg_m[CFG_IDX_MASK3]));

        // CPS-A traffic, the palette base is left for the copy tests
        for (int n = 0; n < 60; n++) begin
            do a = $urandom_range(0, 17); while (a == 5);
            cpsa_write(a, 16'($urandom), 2'($urandom), 1);
            for (int i = 0; i < 18; i++) check_value("cpsa register", cpsa_out(i), cpsa_m[i]);
        end
        cpsa_write(0, 16'h1234, 2'b00, 1);
        check_value("obj_dma_ok", 16'(obj_dma_ok), 16'h1);
        obj_dma_clr = 1'b1;
        @(negedge clk);
        obj_dma_clr = 1'b0;
        check_value("obj_dma_ok", 16'(obj_dma_ok), 16'h0);
        obj_dma_clr = 1'b1;
        cpsa_write(0, 16'h5678, 2'b00, 1);
        check_value("obj_dma_ok", 16'(obj_dma_ok), 16'h1);

        // CPS-B registers through the configured map
        v = 16'($urandom);
        cpsb_access(cfg_addr(CFG_IDX_LAYER), v, 2'b00);
        check_value("layer_ctrl", layer_ctrl, v);
        cpsb_read_check("mmr_dout layer", cfg_addr(CFG_IDX_LAYER), v);
        for (int p = 0; p < 4; p++) begin
            v = 16'($urandom);
            cpsb_access(cfg_addr(CFG_IDX_PRIO0 + p), v, 2'b00);
            check_value("prio", p == 0 ? prio0 : p == 1 ? prio1 : p == 2 ? prio2 : prio3, v);
            cpsb_read_check("mmr_dout prio", cfg_addr(CFG_IDX_PRIO0 + p), v);
        end
        cpsb_access(cfg_addr(CFG_IDX_PAL_PAGE), 16'hff2d, 2'b00);
        check_value("pal_page_en", 16'(pal_page_en), 16'h002d);
        cpsb_read_check("mmr_dout pal_page", cfg_addr(CFG_IDX_PAL_PAGE), 16'h002d);
        cpsb_read_check("mmr_dout id", cfg_addr(CFG_IDX_ID),
                        {4'h0, cfg_m[CFG_IDX_ID_VAL][7:4], 4'h0, cfg_m[CFG_IDX_ID_VAL][3:0]});
        for (int i = 0; i < 31; i++) begin
            if (!used_addr[i]) cpsb_read_check("mmr_dout unmapped", 5'(i), 16'hffff);
        end
        cpsb_read_check("mmr_dout addr 31", 5'd31, 16'hffff);

        for (int n = 0; n < 8; n++) begin
            m1 = 16'($urandom);
            m2 = 16'($urandom);
            cpsb_access(cfg_addr(CFG_IDX_MULT1), m1, 2'b00);
            cpsb_access(cfg_addr(CFG_IDX_MULT2), m2, 2'b00);
            repeat (2) @(negedge clk);
            v = 16'((32'(m1) * 32'(m2)) & 32'hffff);
            cpsb_read_check("mmr_dout rslt0", cfg_addr(CFG_IDX_RSLT0), v);
            v = 16'((32'(m1) * 32'(m2)) >> 16);
            cpsb_read_check("mmr_dout rslt1", cfg_addr(CFG_IDX_RSLT1), v);
        end

        for (int n = 0; n < 6; n++) begin
            @(negedge clk);
            start_button = 4'($urandom);
            coin_input   = 4'($urandom);
            joystick3    = 8'($urandom);
            joystick4    = 8'($urandom);
            in_b = {start_button[2], coin_input[2], joystick3[5:0]};
            cpsb_read_check("mmr_dout in2", cfg_addr(CFG_IDX_IN2), {in_b, in_b});
            in_b = {start_button[3], coin_input[3], joystick4[5:0]};
            cpsb_read_check("mmr_dout in3", cfg_addr(CFG_IDX_IN3), {in_b, in_b});
        end

        // palette copies, the second one with the chip select held longer
        cpsa_write(5, 16'($urandom), 2'b00, 1);
        wait_copies(1);
        cpsb_access(cfg_addr(CFG_IDX_PAL_PAGE), 16'h003f, 2'b00);
        cpsa_write(5, 16'hffff, 2'b00, 3);
        wait_copies(2);
        repeat (2) @(negedge clk);
        check_value("pal_copy pulses", 16'(copy_pulses), 16'h2);

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cps_mmr.f ====
verilog/cps_mmr_pkg.sv
verilog/cpsb_cfg_chain.sv
verilog/cpsa_regs.sv
verilog/cpsb_regs.sv
verilog/pal_copy_seq.sv
verilog/pal_word_counter.sv
verilog/cps_mmr_top.sv
tests/tb_cps_mmr.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cps_mmr testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cps_mmr -f cps_mmr.f -o sim_cps_mmr

./obj_dir/sim_cps_mmr > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    exit 1
fi
